/* Makefile */
# Verilator build, run and lint for the tilemap generator
VERILATOR  ?= verilator
TOP        := tb_tilemap
RTL_TOP    := tilemap_top
FILELIST   := sim.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
+incdir+include
source/tile_pkg.sv
source/layer_ctrl_pkg.sv
source/tile_fetch.sv
source/group_fifo.sv
source/layer_shifter.sv
source/tilemap_top.sv
tests/tb_tilemap.sv

/* source/group_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module group_fifo
	import tile_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input  wire       CLK_2H,
	input  wire       rst,

	input  wire       push,
	input  wire gfx_t push_gfx,
	input  wire attr_t push_attr,
	output logic      full,

	input  wire       pop,
	output logic      empty,
	output gfx_t      pop_gfx,
	output attr_t     pop_attr
);

	localparam int WORD_W = $bits(gfx_t) + $bits(attr_t);
	localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic [CNT_W-1:0]  count_next;
	logic              do_wr;
	logic              do_rd;

	assign do_wr = push && !full;
	assign do_rd = pop && !empty;

	assign count_next = count + CNT_W'(do_wr) - CNT_W'(do_rd);

	// Head word, attribute in the low byte
	assign {pop_gfx, pop_attr} = mem[rd_ptr];

	always_ff @(posedge CLK_2H) begin
		if (do_wr) begin
			mem[wr_ptr] <= {push_gfx, push_attr};
		end
	end

	// Depth is a power of two, pointers wrap naturally
	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
			empty  <= 1'b1;
		end else begin
			wr_ptr <= wr_ptr + PTR_W'(do_wr);
			rd_ptr <= rd_ptr + PTR_W'(do_rd);
			count  <= count_next;
			full   <= (count_next == CNT_W'(FIFO_DEPTH));
			empty  <= (count_next == '0);
		end
	end

endmodule

`default_nettype wire

/* source/layer_ctrl_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////
// Layer control types
//////////////////////////////////////////////////

package layer_ctrl_pkg;

	// Layer priority, higher wins
	typedef logic [2:0] prio_t;

	// Layer select carried on CPU writes
	typedef logic layer_sel_t;

	// Pixel value that lets the chain through
	localparam tile_pkg::pixel_t TRANSPARENT_PIX = 3'd7;

endpackage

`default_nettype wire

/* source/layer_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_shifter
	import tile_pkg::*;
	import layer_ctrl_pkg::*;
#(
	parameter layer_sel_t LAYER      = 1'b0,
	parameter prio_t      RESET_PRIO = 3'd0
) (
	input  wire             CLK_2H,
	input  wire             rst,

	input  wire             flip,
	input  wire             pixel_en,

	// FIFO read side
	input  wire             empty,
	input  wire gfx_t       pop_gfx,
	input  wire attr_t      pop_attr,
	output logic            pop,

	// CPU priority writes
	input  wire             pri_wr,
	input  wire layer_sel_t pri_layer,
	input  wire prio_t      pri_data,

	// Chain in
	input  wire prio_t      prio_in,
	input  wire attr_t      color_in,
	input  wire pixel_t     pixel_in,
	input  wire             valid_in,

	// Chain out
	output prio_t           prio_out,
	output attr_t           color_out,
	output pixel_t          pixel_out,
	output logic            valid_out
);

	plane_t      plane0_sr;
	plane_t      plane1_sr;
	plane_t      plane2_sr;
	attr_t       attr;
	logic [1:0]  pix_pos;
	logic        stage_valid;
	prio_t       layer_prio;

	logic        advance;
	logic        last_pix;
	pixel_t      stage_pix;
	logic        win;

	//////////////////////////////////////////////////
	// Stage control
	//////////////////////////////////////////////////

	assign advance  = stage_valid && pixel_en;
	assign last_pix = advance && (pix_pos == 2'd3);

	// Refill an empty stage at once, or chain groups on the fourth pixel
	assign pop = !empty && (!stage_valid || last_pix);

	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			stage_valid <= 1'b0;
			pix_pos     <= '0;
		end else if (pop) begin
			stage_valid <= 1'b1;
			pix_pos     <= '0;
		end else if (advance) begin
			pix_pos <= pix_pos + 1'b1;
			if (pix_pos == 2'd3) begin
				stage_valid <= 1'b0;
			end
		end
	end

	// Flip shifts towards bit 0, normal order towards bit 3
	always_ff @(posedge CLK_2H) begin
		if (pop) begin
			plane0_sr <= pop_gfx[3:0];
			plane1_sr <= pop_gfx[7:4];
			plane2_sr <= pop_gfx[11:8];
			attr      <= pop_attr;
		end else if (advance) begin
			if (flip) begin
				plane0_sr <= plane0_sr >> 1;
				plane1_sr <= plane1_sr >> 1;
				plane2_sr <= plane2_sr >> 1;
			end else begin
				plane0_sr <= plane0_sr << 1;
				plane1_sr <= plane1_sr << 1;
				plane2_sr <= plane2_sr << 1;
			end
		end
	end

	assign stage_pix = flip ? {plane2_sr[0], plane1_sr[0], plane0_sr[0]}
	                        : {plane2_sr[3], plane1_sr[3], plane0_sr[3]};

	//////////////////////////////////////////////////
	// Priority and mix
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			layer_prio <= RESET_PRIO;
		end else if (pri_wr && (pri_layer == LAYER)) begin
			layer_prio <= pri_data;
		end
	end

	// Strict compare, equal priority passes the chain
	assign win = stage_valid && (stage_pix != TRANSPARENT_PIX) && (layer_prio > prio_in);

	assign prio_out  = win ? layer_prio : prio_in;
	assign color_out = win ? attr : color_in;
	assign pixel_out = win ? stage_pix : pixel_in;
	assign valid_out = valid_in && stage_valid;

endmodule

`default_nettype wire

/* source/tile_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_fetch
	import tile_pkg::*;
	import layer_ctrl_pkg::*;
#(
	parameter layer_sel_t LAYER = 1'b0
) (
	input  wire             CLK_2H,
	input  wire             rst,

	// CPU column writes
	input  wire             map_wr,
	input  wire layer_sel_t map_layer,
	input  wire col_t       map_addr,
	input  wire gfx_t       map_gfx,
	input  wire attr_t      map_attr,

	// CPU scroll writes
	input  wire             scroll_wr,
	input  wire layer_sel_t scroll_layer,
	input  wire col_t       scroll_data,

	input  wire             line_start,

	// FIFO write side
	input  wire             full,
	output logic            push,
	output gfx_t            push_gfx,
	output attr_t           push_attr
);

	typedef enum logic {
		st_idle,
		st_walk
	} fetch_state_t;

	localparam int CNT_W = $clog2(NUM_COLS);

	fetch_state_t     state;
	col_t             scroll_col;
	col_t             fetch_col;
	logic [CNT_W-1:0] walk_cnt;

	gfx_t  gfx_ram [NUM_COLS];
	attr_t attr_ram [NUM_COLS];

	//////////////////////////////////////////////////
	// CPU side
	//////////////////////////////////////////////////

	// Column RAM, plane data stored directly
	always_ff @(posedge CLK_2H) begin
		if (map_wr && (map_layer == LAYER)) begin
			gfx_ram[map_addr]  <= map_gfx;
			attr_ram[map_addr] <= map_attr;
		end
	end

	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			scroll_col <= '0;
		end else if (scroll_wr && (scroll_layer == LAYER)) begin
			scroll_col <= scroll_data;
		end
	end

	//////////////////////////////////////////////////
	// Line walk
	//////////////////////////////////////////////////

	// RAM read every cycle, the word is only taken when push is high
	assign push_gfx  = gfx_ram[fetch_col];
	assign push_attr = attr_ram[fetch_col];
	assign push      = (state == st_walk) && !full;

	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			state     <= st_idle;
			fetch_col <= '0;
			walk_cnt  <= '0;
		end else if (line_start) begin
			// Restart from the scroll column, even mid-walk
			state     <= st_walk;
			fetch_col <= scroll_col;
			walk_cnt  <= '0;
		end else if (push) begin
			// Column wraps on its own at 16
			fetch_col <= fetch_col + 1'b1;
			walk_cnt  <= walk_cnt + 1'b1;
			if (walk_cnt == CNT_W'(NUM_COLS - 1)) begin
				state <= st_idle;
			end
		end
	end

endmodule

`default_nettype wire

/* source/tile_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////
// Pixel data types shared by fetch, FIFO and shifter
//////////////////////////////////////////////////

package tile_pkg;

	// One bit plane of a 4-pixel group
	typedef logic [3:0] plane_t;

	// Three planes, plane 0 in the low nibble
	typedef logic [11:0] gfx_t;

	// Tile attribute, used as the pixel colour
	typedef logic [7:0] attr_t;

	// Pixel index, bit n taken from plane n
	typedef logic [2:0] pixel_t;

	// Column index within one line
	typedef logic [3:0] col_t;

	// Columns walked per line_start
	localparam int NUM_COLS = 16;

endpackage

`default_nettype wire

/* source/tilemap_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tilemap_top
	import tile_pkg::*;
	import layer_ctrl_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input  wire             CLK_2H,
	input  wire             rst,

	input  wire             map_wr,
	input  wire layer_sel_t map_layer,
	input  wire col_t       map_addr,
	input  wire gfx_t       map_gfx,
	input  wire attr_t      map_attr,
	input  wire             scroll_wr,
	input  wire layer_sel_t scroll_layer,
	input  wire col_t       scroll_data,
	input  wire             pri_wr,
	input  wire layer_sel_t pri_layer,
	input  wire prio_t      pri_data,

	input  wire             flip,
	input  wire             line_start,
	input  wire             pixel_en,

	input  wire prio_t      prio_in,
	input  wire attr_t      color_in,
	input  wire pixel_t     pixel_in,
	input  wire             chain_valid,
	output prio_t           prio_out,
	output attr_t           color_out,
	output pixel_t          pixel_out,
	output logic            pix_valid
);

	// Per-layer fetch to FIFO to shifter wires
	logic  push0, push1, full0, full1;
	logic  pop0, pop1, empty0, empty1;
	gfx_t  push_gfx0, push_gfx1, pop_gfx0, pop_gfx1;
	attr_t push_attr0, push_attr1, pop_attr0, pop_attr1;

	// Layer 0 to layer 1 chain
	prio_t  prio_mid;
	attr_t  color_mid;
	pixel_t pixel_mid;
	logic   valid_mid;

	//////////////////////////////////////////////////
	// Layer 0, low end of the chain
	//////////////////////////////////////////////////

	tile_fetch #(.LAYER(1'b0)) fetch0_i (
		.CLK_2H, .rst, .map_wr, .map_layer, .map_addr, .map_gfx, .map_attr,
		.scroll_wr, .scroll_layer, .scroll_data, .line_start,
		.full(full0), .push(push0), .push_gfx(push_gfx0), .push_attr(push_attr0)
	);

	group_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0_i (
		.CLK_2H, .rst,
		.push(push0), .push_gfx(push_gfx0), .push_attr(push_attr0), .full(full0),
		.pop(pop0), .empty(empty0), .pop_gfx(pop_gfx0), .pop_attr(pop_attr0)
	);

	layer_shifter #(.LAYER(1'b0), .RESET_PRIO(3'd2)) shift0_i (
		.CLK_2H, .rst, .flip, .pixel_en,
		.empty(empty0), .pop_gfx(pop_gfx0), .pop_attr(pop_attr0), .pop(pop0),
		.pri_wr, .pri_layer, .pri_data,
		.prio_in, .color_in, .pixel_in, .valid_in(chain_valid),
		.prio_out(prio_mid), .color_out(color_mid), .pixel_out(pixel_mid),
		.valid_out(valid_mid)
	);

	//////////////////////////////////////////////////
	// Layer 1, drives the top outputs
	//////////////////////////////////////////////////

	tile_fetch #(.LAYER(1'b1)) fetch1_i (
		.CLK_2H, .rst, .map_wr, .map_layer, .map_addr, .map_gfx, .map_attr,
		.scroll_wr, .scroll_layer, .scroll_data, .line_start,
		.full(full1), .push(push1), .push_gfx(push_gfx1), .push_attr(push_attr1)
	);

	group_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo1_i (
		.CLK_2H, .rst,
		.push(push1), .push_gfx(push_gfx1), .push_attr(push_attr1), .full(full1),
		.pop(pop1), .empty(empty1), .pop_gfx(pop_gfx1), .pop_attr(pop_attr1)
	);

	layer_shifter #(.LAYER(1'b1), .RESET_PRIO(3'd3)) shift1_i (
		.CLK_2H, .rst, .flip, .pixel_en,
		.empty(empty1), .pop_gfx(pop_gfx1), .pop_attr(pop_attr1), .pop(pop1),
		.pri_wr, .pri_layer, .pri_data,
		.prio_in(prio_mid), .color_in(color_mid), .pixel_in(pixel_mid),
		.valid_in(valid_mid),
		.prio_out, .color_out, .pixel_out, .valid_out(pix_valid)
	);

endmodule

`default_nettype wire

/* include/tb_tilemap_tasks.svh */
`ifndef TB_TILEMAP_TASKS_SVH
`define TB_TILEMAP_TASKS_SVH

//////////////////////////////////////////////////
// Reference model state
//////////////////////////////////////////////////

localparam int PIX_PER_LINE = NUM_COLS * 4;
localparam int PIX_TIMEOUT  = 64;

gfx_t  model_gfx [2][NUM_COLS];
attr_t model_attr [2][NUM_COLS];
col_t  model_scroll [2];
prio_t model_prio [2];

task automatic stop_with_failure();
	$display("SOME TESTS FAILED");
	$fatal(1, "simulation stopped on the first error");
endtask

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic check_prio(input string name, input int idx, input prio_t got, input prio_t exp);
	if (got !== exp) begin
		$display("** Error: %s pixel %0d got 0x%h expected 0x%h", name, idx, got, exp);
		stop_with_failure();
	end
endtask

task automatic check_color(input string name, input int idx, input attr_t got, input attr_t exp);
	if (got !== exp) begin
		$display("** Error: %s pixel %0d got 0x%h expected 0x%h", name, idx, got, exp);
		stop_with_failure();
	end
endtask

task automatic check_pixel(input string name, input int idx, input pixel_t got,
		input pixel_t exp);
	if (got !== exp) begin
		$display("** Error: %s pixel %0d got 0x%h expected 0x%h", name, idx, got, exp);
		stop_with_failure();
	end
endtask

task automatic check_valid(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
		stop_with_failure();
	end
endtask

//////////////////////////////////////////////////
// CPU write drivers, each starts and ends 1 ns after an edge
//////////////////////////////////////////////////

task automatic write_column(input layer_sel_t l, input col_t a, input gfx_t g, input attr_t at);
	map_wr = 1'b1;
	map_layer = l;
	map_addr = a;
	map_gfx = g;
	map_attr = at;
	@(posedge CLK_2H);
	#1;
	map_wr = 1'b0;
	model_gfx[l][a] = g;
	model_attr[l][a] = at;
endtask

task automatic set_scroll(input layer_sel_t l, input col_t s);
	scroll_wr = 1'b1;
	scroll_layer = l;
	scroll_data = s;
	@(posedge CLK_2H);
	#1;
	scroll_wr = 1'b0;
	model_scroll[l] = s;
endtask

task automatic set_priority(input layer_sel_t l, input prio_t p);
	pri_wr = 1'b1;
	pri_layer = l;
	pri_data = p;
	@(posedge CLK_2H);
	#1;
	pri_wr = 1'b0;
	model_prio[l] = p;
endtask

task automatic fill_map(input bit transparent);
	int l;
	int c;
	for (l = 0; l < 2; l++) begin
		for (c = 0; c < NUM_COLS; c++) begin
			// All planes set gives pixel 7 everywhere
			write_column(layer_sel_t'(l), col_t'(c),
				transparent ? 12'hfff : gfx_t'($urandom), attr_t'($urandom));
		end
	end
endtask

// Pixel idx of the line after both layers, chain input as driven now
task automatic expect_pixel(input int idx, output prio_t ep, output attr_t ec, output pixel_t epx);
	int     l;
	int     bitn;
	col_t   col;
	gfx_t   g;
	pixel_t lp;
	ep = prio_in;
	ec = color_in;
	epx = pixel_in;
	bitn = flip ? (idx % 4) : 3 - (idx % 4);
	for (l = 0; l < 2; l++) begin
		col = col_t'(int'(model_scroll[l]) + idx / 4);
		g = model_gfx[l][col];
		lp = {g[8 + bitn], g[4 + bitn], g[bitn]};
		if ((lp != TRANSPARENT_PIX) && (model_prio[l] > ep)) begin
			ep = model_prio[l];
			ec = model_attr[l][col];
			epx = lp;
		end
	end
endtask

`endif

/* tests/tb_tilemap.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tilemap
	import tile_pkg::*;
	import layer_ctrl_pkg::*;
();

	logic       CLK_2H;
	logic       rst;
	logic       map_wr, scroll_wr, pri_wr;
	layer_sel_t map_layer, scroll_layer, pri_layer;
	col_t       map_addr, scroll_data;
	gfx_t       map_gfx;
	attr_t      map_attr;
	prio_t      pri_data;
	logic       flip, line_start, pixel_en, chain_valid;
	prio_t      prio_in, prio_out;
	attr_t      color_in, color_out;
	pixel_t     pixel_in, pixel_out;
	logic       pix_valid;

	tilemap_top #(.FIFO_DEPTH(4)) dut_i (
		.CLK_2H, .rst, .map_wr, .map_layer, .map_addr, .map_gfx, .map_attr,
		.scroll_wr, .scroll_layer, .scroll_data, .pri_wr, .pri_layer, .pri_data,
		.flip, .line_start, .pixel_en, .prio_in, .color_in, .pixel_in, .chain_valid,
		.prio_out, .color_out, .pixel_out, .pix_valid
	);

	`include "tb_tilemap_tasks.svh"

	always #5 CLK_2H = ~CLK_2H;

	// Check one line of 64 pixels in the order pixel_en takes them
	task automatic run_line(input bit random_en);
		int     idx;
		int     wait_cnt;
		prio_t  ep;
		attr_t  ec;
		pixel_t epx;
		idx = 0;
		wait_cnt = 0;
		pixel_en = random_en ? 1'($urandom) : 1'b1;
		chain_valid = pixel_en ? 1'b1 : 1'($urandom);
		line_start = 1'b1;
		@(posedge CLK_2H);
		#1;
		line_start = 1'b0;
		while (idx < PIX_PER_LINE) begin
			@(negedge CLK_2H);
			// A dropped chain masks the layer output
			if (!chain_valid) begin
				check_valid("pix_valid", pix_valid, 1'b0);
			end
			if (pix_valid && pixel_en) begin
				expect_pixel(idx, ep, ec, epx);
				check_prio("prio_out", idx, prio_out, ep);
				check_color("color_out", idx, color_out, ec);
				check_pixel("pixel_out", idx, pixel_out, epx);
				idx++;
				wait_cnt = 0;
			end else begin
				wait_cnt++;
				if (wait_cnt > PIX_TIMEOUT) begin
					$display("Timed out waiting for pixel %0d of the line", idx);
					stop_with_failure();
				end
			end
			@(posedge CLK_2H);
			#1;
			if (random_en) begin
				pixel_en = 1'($urandom);
				// Chain drops out only while the stage is held
				chain_valid = pixel_en ? 1'b1 : 1'($urandom);
			end
		end
		pixel_en = 1'b1;
		chain_valid = 1'b1;
		idle_check(4);
	endtask

	// No pixel may show while no line is in flight
	task automatic idle_check(input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge CLK_2H);
			check_valid("pix_valid", pix_valid, 1'b0);
			@(posedge CLK_2H);
			#1;
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic opaque_mix_line();
		fill_map(1'b0);
		prio_in = 3'd0;
		pixel_in = 3'd7;
		color_in = attr_t'($urandom);
		run_line(1'b0);
	endtask

	task automatic flipped_line();
		fill_map(1'b0);
		flip = 1'b1;
		run_line(1'b0);
		flip = 1'b0;
	endtask

	task automatic transparent_line();
		fill_map(1'b1);
		prio_in = 3'd1;
		pixel_in = 3'd4;
		color_in = attr_t'($urandom);
		run_line(1'b0);
	endtask

	task automatic priority_lines();
		fill_map(1'b0);
		prio_in = 3'd0;
		pixel_in = 3'd7;
		// Layer 0 above layer 1
		set_priority(1'b0, 3'd5);
		run_line(1'b0);
		// Chain at the top layer's priority passes through
		prio_in = 3'd5;
		run_line(1'b0);
		// Write aimed at layer 0 leaves layer 1 at 3
		prio_in = 3'd0;
		set_priority(1'b0, 3'd1);
		run_line(1'b0);
		set_priority(1'b0, 3'd2);
	endtask

	task automatic scrolled_line();
		fill_map(1'b0);
		set_scroll(1'b0, 4'd5);
		set_scroll(1'b1, 4'd13);
		run_line(1'b0);
	endtask

	task automatic stalled_line();
		fill_map(1'b0);
		set_scroll(1'b0, 4'd11);
		set_scroll(1'b1, 4'd2);
		color_in = attr_t'($urandom);
		run_line(1'b1);
		set_scroll(1'b0, 4'd0);
		set_scroll(1'b1, 4'd0);
	endtask

	initial begin
		void'($urandom(32'h1d27a465));
		CLK_2H = 1'b0;
		rst = 1'b1;
		map_wr = 1'b0;
		map_layer = 1'b0;
		map_addr = '0;
		map_gfx = '0;
		map_attr = '0;
		scroll_wr = 1'b0;
		scroll_layer = 1'b0;
		scroll_data = '0;
		pri_wr = 1'b0;
		pri_layer = 1'b0;
		pri_data = '0;
		flip = 1'b0;
		line_start = 1'b0;
		pixel_en = 1'b1;
		chain_valid = 1'b1;
		prio_in = '0;
		color_in = '0;
		pixel_in = 3'd7;
		model_scroll[0] = '0;
		model_scroll[1] = '0;
		model_prio[0] = 3'd2;
		model_prio[1] = 3'd3;

		repeat (4) @(posedge CLK_2H);
		#1;
		rst = 1'b0;

		idle_check(8);
		opaque_mix_line();
		flipped_line();
		transparent_line();
		priority_lines();
		scrolled_line();
		stalled_line();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
